// ==== logic/i3c_tti_pkg.sv ====
// TTI queue definitions
package i3c_tti_pkg;

  // Queue entry widths.
  localparam int unsigned TxDescWidth = 32;
  localparam int unsigned TxWordWidth = 32;

  // Queue depths, in entries.
  localparam int unsigned TxDescDepth = 4;
  localparam int unsigned TxDataDepth = 16;

  // A fill level must reach the full depth, so it needs one bit more than an index.
  localparam int unsigned LevelWidth = $clog2(TxDataDepth + 1);

  // One TX descriptor as pushed by software. Bits 15:0 hold the byte count.
  typedef logic [TxDescWidth-1:0] tx_desc_t;

  // One TX data word. Byte 0 sits in bits 7:0 and leaves first.
  typedef logic [TxWordWidth-1:0] tx_word_t;

  // Message length or bytes still to go.
  typedef logic [15:0] byte_count_t;

  // Number of entries held by a queue.
  typedef logic [LevelWidth-1:0] queue_level_t;

endpackage

// ==== logic/i3c_target_pkg.sv ====
// I3C target bus-side definitions
package i3c_target_pkg;

  // A data byte as seen by the bus engine.
  typedef logic [7:0] bus_byte_t;

  // Private-read responder states.
  // IDLE waits for a read, RESPOND answers with ACK or NACK, SEND moves the bytes.
  typedef enum logic [1:0] {
    IDLE,
    RESPOND,
    SEND
  } read_state_e;

endpackage

// ==== logic/tti_queue.sv ====
// TTI synchronous queue
`timescale 1ns/1ps

module tti_queue #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  logic [Width-1:0]          wdata_i,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [Width-1:0]          rdata_o,
  output i3c_tti_pkg::queue_level_t level_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0]          mem_q [Depth];
  logic [PtrWidth-1:0]       wr_ptr_q;
  logic [PtrWidth-1:0]       rd_ptr_q;
  i3c_tti_pkg::queue_level_t count_q;
  logic                      push;
  logic                      pop;

  // Pointers wrap at Depth, which need not be a power of two.
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wready_o = (count_q != i3c_tti_pkg::queue_level_t'(Depth));
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;
  assign rdata_o  = mem_q[rd_ptr_q];  // Head entry, shown as soon as it is stored.
  assign level_o  = count_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither leave the level as it is.
      endcase
    end
  end

  // A push held off by a full queue stays offered with the same data until it is taken.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wvalid_i && !wready_o) |=> (wvalid_i && $stable(wdata_i)));

endmodule

// ==== logic/tx_word_to_byte.sv ====
// TX word to byte converter
`timescale 1ns/1ps

module tx_word_to_byte (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      word_valid_i,
  output logic                      word_ready_o,
  input  i3c_tti_pkg::tx_word_t     word_i,
  output logic                      byte_valid_o,
  input  logic                      byte_ready_i,
  output i3c_target_pkg::bus_byte_t byte_o,
  output logic                      holding_o,
  input  logic                      flush_i
);

  i3c_tti_pkg::tx_word_t word_q;
  logic [1:0]            idx_q;
  logic                  holding_q;
  logic                  last_byte_fire;

  assign byte_valid_o   = holding_q;
  assign byte_o         = word_q[{idx_q, 3'b000} +: 8];  // Least-significant byte first.
  assign holding_o      = holding_q;
  assign last_byte_fire = holding_q && byte_ready_i && (idx_q == 2'd3);

  // A new word can enter while empty, or in the cycle the fourth byte leaves.
  assign word_ready_o = (!holding_q || last_byte_fire) && !flush_i;

  always_ff @(posedge clk_i) begin
    if (word_valid_i && word_ready_o) begin
      word_q <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holding_q <= 1'b0;
      idx_q     <= '0;
    end else if (flush_i) begin
      // The rest of the held word belongs to a finished message.
      holding_q <= 1'b0;
      idx_q     <= '0;
    end else if (word_valid_i && word_ready_o) begin
      holding_q <= 1'b1;
      idx_q     <= '0;
    end else if (holding_q && byte_ready_i) begin
      idx_q <= idx_q + 1'b1;  // Wraps to zero after byte 3.
      if (idx_q == 2'd3) begin
        holding_q <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/descriptor_tx.sv ====
// TX descriptor handler
`timescale 1ns/1ps

module descriptor_tx (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      desc_valid_i,
  output logic                      desc_ready_o,
  input  i3c_tti_pkg::tx_desc_t     desc_i,
  input  i3c_tti_pkg::queue_level_t data_level_i,
  input  logic                      conv_holding_i,
  input  logic                      byte_valid_i,
  output logic                      byte_ready_o,
  input  i3c_target_pkg::bus_byte_t byte_i,
  output logic                      conv_flush_o,
  input  logic                      tx_start_i,
  input  logic                      tx_abort_i,
  output logic                      tx_desc_avail_o,
  output i3c_target_pkg::bus_byte_t tx_byte_o,
  output logic                      tx_byte_valid_o,
  input  logic                      tx_byte_ready_i,
  output logic                      tx_byte_last_o
);

  i3c_tti_pkg::tx_desc_t     desc_q;
  i3c_tti_pkg::byte_count_t  count_q;
  i3c_tti_pkg::byte_count_t  data_len;
  i3c_tti_pkg::byte_count_t  words_needed;
  i3c_tti_pkg::byte_count_t  words_avail;
  logic [16:0]               len_round;
  logic                      desc_held_q;
  logic                      pending_q;
  logic                      flush_q;
  logic                      start;
  logic                      byte_fire;
  logic                      tx_end;

  assign data_len     = desc_q[15:0];
  assign len_round    = {1'b0, data_len} + 17'd3;
  assign words_needed = i3c_tti_pkg::byte_count_t'(len_round[16:2]);
  // The word inside the converter counts as available data too.
  assign words_avail  = i3c_tti_pkg::byte_count_t'(data_level_i)
                      + i3c_tti_pkg::byte_count_t'(conv_holding_i);

  // A descriptor is only offered once the previous message is fully gone.
  assign tx_desc_avail_o = desc_valid_i && !desc_held_q && !flush_q;
  assign desc_ready_o    = tx_desc_avail_o && tx_start_i && !tx_abort_i;

  assign start = desc_held_q && !pending_q && !flush_q && (words_avail >= words_needed);

  // While draining after an abort, converter bytes are swallowed here.
  assign byte_ready_o    = flush_q || (pending_q && tx_byte_ready_i);
  assign byte_fire       = byte_valid_i && byte_ready_o;
  assign tx_byte_valid_o = pending_q && byte_valid_i;
  assign tx_byte_o       = byte_i;
  assign tx_byte_last_o  = (count_q == 16'd1);

  assign tx_end       = byte_fire && (count_q == 16'd1);
  assign conv_flush_o = tx_end && (data_len[1:0] != 2'b00);  // Drop the unused tail bytes.

  always_ff @(posedge clk_i) begin
    if (desc_ready_o && desc_valid_i) begin
      desc_q <= desc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_held_q <= 1'b0;
      pending_q   <= 1'b0;
      flush_q     <= 1'b0;
      count_q     <= '0;
    end else begin
      if (desc_ready_o && desc_valid_i) begin
        desc_held_q <= 1'b1;
        count_q     <= desc_i[15:0];
      end else if (byte_fire) begin
        count_q <= count_q - 1'b1;
      end
      if (tx_end || tx_abort_i) desc_held_q <= 1'b0;
      if (start) begin
        pending_q <= 1'b1;
      end else if (tx_end || tx_abort_i) begin
        pending_q <= 1'b0;
      end
      // An abort on the last byte has nothing left to drain.
      if (tx_abort_i && desc_held_q && !tx_end && (count_q != '0)) begin
        flush_q <= 1'b1;
      end else if (tx_end) begin
        flush_q <= 1'b0;
      end
    end
  end

  // The remaining count always shrinks by one per accepted byte, so it never wraps.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_fire |=> (count_q < $past(count_q)));

  // Bytes only go out for a message whose descriptor is held.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(tx_byte_valid_o) |-> desc_held_q);

endmodule

// ==== logic/target_read_ctrl.sv ====
// Private read responder
`timescale 1ns/1ps

module target_read_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      read_req_i,
  output logic                      read_ack_o,
  output logic                      read_nack_o,
  input  logic                      bus_abort_i,
  output i3c_target_pkg::bus_byte_t bus_byte_o,
  output logic                      bus_byte_valid_o,
  input  logic                      bus_byte_ready_i,
  output logic                      bus_tbit_o,
  input  logic                      tx_desc_avail_i,
  output logic                      tx_start_o,
  output logic                      tx_abort_o,
  input  i3c_target_pkg::bus_byte_t tx_byte_i,
  input  logic                      tx_byte_valid_i,
  output logic                      tx_byte_ready_o,
  input  logic                      tx_byte_last_i
);

  i3c_target_pkg::read_state_e state_q;
  i3c_target_pkg::read_state_e state_d;
  logic                        in_respond;
  logic                        in_send;

  assign in_respond = (state_q == i3c_target_pkg::RESPOND);
  assign in_send    = (state_q == i3c_target_pkg::SEND);

  // The answer is given in the cycle after the request. An abort then turns it into a NACK.
  assign read_ack_o  = in_respond && tx_desc_avail_i && !bus_abort_i;
  assign read_nack_o = in_respond && (!tx_desc_avail_i || bus_abort_i);
  assign tx_start_o  = read_ack_o;
  assign tx_abort_o  = in_send && bus_abort_i;

  // Bytes pass straight through while sending.
  assign bus_byte_o       = tx_byte_i;
  assign bus_byte_valid_o = in_send && tx_byte_valid_i;
  assign tx_byte_ready_o  = in_send && bus_byte_ready_i;
  assign bus_tbit_o       = bus_byte_valid_o && tx_byte_last_i;  // T-bit ends the read.

  always_comb begin
    state_d = state_q;
    case (state_q)
      i3c_target_pkg::IDLE: begin
        if (read_req_i) state_d = i3c_target_pkg::RESPOND;
      end
      i3c_target_pkg::RESPOND: begin
        state_d = read_ack_o ? i3c_target_pkg::SEND : i3c_target_pkg::IDLE;
      end
      i3c_target_pkg::SEND: begin
        if (bus_abort_i) begin
          state_d = i3c_target_pkg::IDLE;
        end else if (bus_byte_valid_o && bus_byte_ready_i && tx_byte_last_i) begin
          state_d = i3c_target_pkg::IDLE;  // Last byte has gone out.
        end
      end
      default: state_d = i3c_target_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_target_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Every answer follows a request one cycle earlier, and never both at once.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (read_ack_o || read_nack_o) |-> ($past(read_req_i) && !(read_ack_o && read_nack_o)));

endmodule

// ==== logic/tti_tx_top.sv ====
// TTI transmit path top level
`timescale 1ns/1ps

module tti_tx_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      desc_wvalid_i,
  output logic                      desc_wready_o,
  input  i3c_tti_pkg::tx_desc_t     desc_wdata_i,
  input  logic                      data_wvalid_i,
  output logic                      data_wready_o,
  input  i3c_tti_pkg::tx_word_t     data_wdata_i,
  input  logic                      read_req_i,
  output logic                      read_ack_o,
  output logic                      read_nack_o,
  output i3c_target_pkg::bus_byte_t bus_byte_o,
  output logic                      bus_byte_valid_o,
  input  logic                      bus_byte_ready_i,
  output logic                      bus_tbit_o,
  input  logic                      bus_abort_i
);

  logic                      desc_rvalid;
  logic                      desc_rready;
  i3c_tti_pkg::tx_desc_t     desc_rdata;
  logic                      data_rvalid;
  logic                      data_rready;
  i3c_tti_pkg::tx_word_t     data_rdata;
  i3c_tti_pkg::queue_level_t data_level;
  logic                      conv_valid;
  logic                      conv_ready;
  i3c_target_pkg::bus_byte_t conv_byte;
  logic                      conv_holding;
  logic                      conv_flush;
  logic                      tx_desc_avail;
  logic                      tx_start;
  logic                      tx_abort;
  i3c_target_pkg::bus_byte_t tx_byte;
  logic                      tx_byte_valid;
  logic                      tx_byte_ready;
  logic                      tx_byte_last;

  // The descriptor fill level is not needed, only whether one is waiting.
  tti_queue #(
    .Width(i3c_tti_pkg::TxDescWidth),
    .Depth(i3c_tti_pkg::TxDescDepth)
  ) desc_queue_i (
    .clk_i, .rst_ni,
    .wvalid_i(desc_wvalid_i), .wready_o(desc_wready_o), .wdata_i(desc_wdata_i),
    .rvalid_o(desc_rvalid), .rready_i(desc_rready), .rdata_o(desc_rdata),
    .level_o()
  );

  tti_queue #(
    .Width(i3c_tti_pkg::TxWordWidth),
    .Depth(i3c_tti_pkg::TxDataDepth)
  ) data_queue_i (
    .clk_i, .rst_ni,
    .wvalid_i(data_wvalid_i), .wready_o(data_wready_o), .wdata_i(data_wdata_i),
    .rvalid_o(data_rvalid), .rready_i(data_rready), .rdata_o(data_rdata),
    .level_o(data_level)
  );

  tx_word_to_byte conv_i (
    .clk_i, .rst_ni,
    .word_valid_i(data_rvalid), .word_ready_o(data_rready), .word_i(data_rdata),
    .byte_valid_o(conv_valid), .byte_ready_i(conv_ready), .byte_o(conv_byte),
    .holding_o(conv_holding), .flush_i(conv_flush)
  );

  descriptor_tx desc_tx_i (
    .clk_i, .rst_ni,
    .desc_valid_i(desc_rvalid), .desc_ready_o(desc_rready), .desc_i(desc_rdata),
    .data_level_i(data_level), .conv_holding_i(conv_holding),
    .byte_valid_i(conv_valid), .byte_ready_o(conv_ready), .byte_i(conv_byte),
    .conv_flush_o(conv_flush), .tx_start_i(tx_start), .tx_abort_i(tx_abort),
    .tx_desc_avail_o(tx_desc_avail), .tx_byte_o(tx_byte),
    .tx_byte_valid_o(tx_byte_valid), .tx_byte_ready_i(tx_byte_ready),
    .tx_byte_last_o(tx_byte_last)
  );

  target_read_ctrl read_ctrl_i (
    .clk_i, .rst_ni,
    .read_req_i, .read_ack_o, .read_nack_o, .bus_abort_i,
    .bus_byte_o, .bus_byte_valid_o, .bus_byte_ready_i, .bus_tbit_o,
    .tx_desc_avail_i(tx_desc_avail), .tx_start_o(tx_start), .tx_abort_o(tx_abort),
    .tx_byte_i(tx_byte), .tx_byte_valid_i(tx_byte_valid),
    .tx_byte_ready_o(tx_byte_ready), .tx_byte_last_i(tx_byte_last)
  );

endmodule

// ==== test/tb_tti_tx.sv ====
// TTI transmit path testbench
`timescale 1ns/1ps

module tb_tti_tx;

  localparam int          NumTests = 12;
  localparam logic [31:0] SeedInit = 32'h6cd9_09a2;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      desc_wvalid_i;
  logic                      desc_wready_o;
  i3c_tti_pkg::tx_desc_t     desc_wdata_i;
  logic                      data_wvalid_i;
  logic                      data_wready_o;
  i3c_tti_pkg::tx_word_t     data_wdata_i;
  logic                      read_req_i;
  logic                      read_ack_o;
  logic                      read_nack_o;
  i3c_target_pkg::bus_byte_t bus_byte_o;
  logic                      bus_byte_valid_o;
  logic                      bus_byte_ready_i;
  logic                      bus_tbit_o;
  logic                      bus_abort_i;

  // Test table with one entry per index.
  string test_name [NumTests];
  int    test_len [NumTests];
  int    test_seed_ofs [NumTests];
  int    test_abort_after [NumTests];  // Zero lets the message run to its end.
  bit    test_no_desc [NumTests];      // A read is tried while only data is queued.
  bit    test_stall [NumTests];
  bit    test_data_late [NumTests];    // Descriptor goes in before its data.

  logic [31:0] model_q [$];  // Words pushed but not yet used up by a message.
  integer      seed;
  integer      data_seed;
  int          errors;
  int          failed_tests;

  tti_tx_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic add_test(input int i, input string name, input int len, input int ofs,
                          input int abort_after, input bit no_desc, input bit stall,
                          input bit data_late);
    test_name[i]        = name;
    test_len[i]         = len;
    test_seed_ofs[i]    = ofs;
    test_abort_after[i] = abort_after;
    test_no_desc[i]     = no_desc;
    test_stall[i]       = stall;
    test_data_late[i]   = data_late;
  endtask

  // Inputs change 1 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic push_data(input logic [31:0] w);
    logic taken;
    data_wvalid_i = 1'b1;
    data_wdata_i  = w;
    do begin
      #1;
      taken = data_wready_o;
      next_cycle();
    end while (!taken);
    data_wvalid_i = 1'b0;
  endtask

  task automatic push_desc(input logic [31:0] d);
    logic taken;
    desc_wvalid_i = 1'b1;
    desc_wdata_i  = d;
    do begin
      #1;
      taken = desc_wready_o;
      next_cycle();
    end while (!taken);
    desc_wvalid_i = 1'b0;
  endtask

  // Words continue the pattern of the current test from its data seed.
  task automatic push_words(input int count);
    logic [31:0] w;
    repeat (count) begin
      w = $random(data_seed);
      model_q.push_back(w);
      push_data(w);
    end
  endtask

  task automatic request_read(output logic ack, output logic nack);
    read_req_i = 1'b1;
    next_cycle();
    read_req_i = 1'b0;
    #1;  // Answer is due in this cycle.
    ack  = read_ack_o;
    nack = read_nack_o;
    next_cycle();
  endtask

  task automatic expect_quiet(input int t, input int cycles);
    repeat (cycles) begin
      #1;
      if (bus_byte_valid_o !== 1'b0) begin
        $display("FAIL %s: a byte was offered on the bus while none was due", test_name[t]);
        errors++;
      end
      next_cycle();
    end
  endtask

  // Bytes leave least-significant first, taken from the model words in push order.
  task automatic collect_bytes(input int t);
    int          idx;
    int          target;
    logic [31:0] w;
    logic [7:0]  exp_byte;
    logic        exp_tbit;
    idx    = 0;
    target = (test_abort_after[t] != 0) ? test_abort_after[t] : test_len[t];
    while (idx < target) begin
      bus_byte_ready_i = test_stall[t] ? (($random(seed) & 3) != 0) : 1'b1;
      #1;
      if (bus_byte_valid_o && bus_byte_ready_i) begin
        w        = model_q[idx / 4];
        exp_byte = w[8 * (idx % 4) +: 8];
        exp_tbit = (idx == test_len[t] - 1);
        if (bus_byte_o !== exp_byte) begin
          $display("FAIL %s: byte %0d expected %02h actual %02h",
                   test_name[t], idx, exp_byte, bus_byte_o);
          errors++;
        end
        if (bus_tbit_o !== exp_tbit) begin
          $display("FAIL %s: T-bit of byte %0d expected %0b actual %0b",
                   test_name[t], idx, exp_tbit, bus_tbit_o);
          errors++;
        end
        idx++;
      end
      next_cycle();
    end
    bus_byte_ready_i = 1'b0;
  endtask

  initial begin
    int   limit_ns;
    int   errs_before;
    int   nwords;
    logic ack;
    logic nack;
    seed             = SeedInit;
    errors           = 0;
    failed_tests     = 0;
    rst_ni           = 1'b0;
    desc_wvalid_i    = 1'b0;
    desc_wdata_i     = '0;
    data_wvalid_i    = 1'b0;
    data_wdata_i     = '0;
    read_req_i       = 1'b0;
    bus_byte_ready_i = 1'b0;
    bus_abort_i      = 1'b0;

    add_test(0,  "nack_no_desc", 4,  0, 0, 1'b1, 1'b0, 1'b0);
    add_test(1,  "len_4",        4,  1, 0, 1'b0, 1'b0, 1'b0);
    add_test(2,  "len_8",        8,  2, 0, 1'b0, 1'b0, 1'b0);
    add_test(3,  "len_16",      16,  3, 0, 1'b0, 1'b0, 1'b0);
    add_test(4,  "len_1",        1,  4, 0, 1'b0, 1'b0, 1'b0);
    add_test(5,  "len_5",        5,  5, 0, 1'b0, 1'b0, 1'b0);
    add_test(6,  "len_7",        7,  6, 0, 1'b0, 1'b0, 1'b0);
    add_test(7,  "stall_16",    16,  7, 0, 1'b0, 1'b1, 1'b0);
    add_test(8,  "stall_7",      7,  8, 0, 1'b0, 1'b1, 1'b0);
    add_test(9,  "abort_at_2",  10,  9, 2, 1'b0, 1'b0, 1'b0);
    add_test(10, "after_abort",  8, 10, 0, 1'b0, 1'b0, 1'b0);
    add_test(11, "late_data",   10, 11, 0, 1'b0, 1'b0, 1'b1);

    limit_ns = 1000 + NumTests * 200;
    for (int t = 0; t < NumTests; t++) limit_ns += test_len[t] * 40;
    fork
      begin
        #(limit_ns);
        $display("Run stopped after %0d ns because the DUT stopped responding", limit_ns);
        $display("TEST FAILED");
        $finish;
      end
    join_none

    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    next_cycle();
    if ({read_ack_o, read_nack_o, bus_byte_valid_o} !== 3'b000) begin
      $display("FAIL reset: bus outputs were not idle after reset");
      errors++;
    end

    for (int t = 0; t < NumTests; t++) begin
      errs_before = errors;
      nwords      = (test_len[t] + 3) / 4;
      data_seed   = SeedInit + test_seed_ofs[t];
      if (!test_data_late[t]) push_words(nwords);
      if (test_no_desc[t]) begin
        // Data is waiting but no descriptor, so the read is refused.
        request_read(ack, nack);
        if (ack !== 1'b0 || nack !== 1'b1) begin
          $display("FAIL %s: ack/nack expected 0/1 actual %0b/%0b", test_name[t], ack, nack);
          errors++;
        end
        expect_quiet(t, 8);
      end
      push_desc({16'(t), 16'(test_len[t])});  // Upper bits carry noise only.
      request_read(ack, nack);
      if (ack !== 1'b1 || nack !== 1'b0) begin
        $display("FAIL %s: ack/nack expected 1/0 actual %0b/%0b", test_name[t], ack, nack);
        errors++;
      end
      if (test_data_late[t]) begin
        // One word short of the message, so nothing may start yet.
        push_words(nwords - 1);
        expect_quiet(t, 6);
        push_words(1);
      end
      collect_bytes(t);
      if (test_abort_after[t] != 0) begin
        bus_abort_i = 1'b1;
        next_cycle();
        bus_abort_i = 1'b0;
        // The handler drains the rest of the message at one byte per cycle.
        repeat (test_len[t] - test_abort_after[t] + 2) next_cycle();
      end
      expect_quiet(t, 2);
      repeat (nwords) model_q.delete(0);
      if (errors == errs_before) begin
        $display("test %s passed", test_name[t]);
      end else begin
        failed_tests++;
        $display("test %s failed with %0d errors", test_name[t], errors - errs_before);
      end
    end

    $display("%0d tests run, %0d failed, %0d failed checks", NumTests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/i3c_tti_pkg.sv
logic/i3c_target_pkg.sv
logic/tti_queue.sv
logic/tx_word_to_byte.sv
logic/descriptor_tx.sv
logic/target_read_ctrl.sv
logic/tti_tx_top.sv
test/tb_tti_tx.sv

// ==== Makefile ====
# Verilator flow for the TTI transmit path

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= tb_tti_tx
RTL_TOP    ?= tti_tx_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
